// ==== hdl/ifill_defs.svh ====
/*
 * Shared constants for the instruction-fill bridge:
 * L1.5 request and return type codes, the PCX size code,
 * and the address and data widths used by the RTL and testbench
 */

`ifndef IFILL_DEFS_SVH
`define IFILL_DEFS_SVH

// Request type sent to the L1.5 for an instruction miss
`define IMISS_RQ        5'b10000

// Return types coming back from the L1.5
// Instruction fill carries the line in data_2 and data_3
`define IFILL_RET       4'b0001
// Interrupt return carries the wake field in data_0
`define INT_RET         4'b0111

// PCX size code for a four-byte access
`define PCX_SZ_4B       3'b010

// Core side address width
`define CORE_ADDR_W     32

// L1.5 side address width, core address is sign-extended up to this
`define L15_ADDR_W      40

// Low address bits cleared to align a fetch to the cache line
`define LINE_OFFSET_W   5

// Width of one instruction word handed to the core
`define WORD_W          32

// Width of each L1.5 data beat
`define L15_DATA_W      64

// LSB of the two-bit wake field inside data_0 of an interrupt return
`define WAKE_FIELD_LO   16

`endif

// ==== hdl/ifill_pkg.sv ====
/*
 * Bus types for the instruction-fill bridge:
 * the L1.5 request and response bundles, the four-word fill
 * line and the fetch bundle returned to the core
 */

`include "ifill_defs.svh"

package ifill_pkg;

    // Request toward the L1.5, 49 bits
    typedef struct packed {
        logic                   val;
        logic [4:0]             rqtype;
        logic [`L15_ADDR_W-1:0] address;
        logic [2:0]             size;
    } l15_req_t;

    // Response from the L1.5
    // Only the beats this bridge looks at are carried
    typedef struct packed {
        logic                   val;
        logic [3:0]             returntype;
        // Interrupt payload, wake field lives here
        logic [`L15_DATA_W-1:0] data_0;
        // Fill words 0 and 1, big-endian
        logic [`L15_DATA_W-1:0] data_2;
        // Fill words 2 and 3, big-endian
        logic [`L15_DATA_W-1:0] data_3;
    } l15_resp_t;

    // Byte-swapped fill line, word 0 in the top bits
    // so the whole struct reads as the assembled line
    typedef struct packed {
        logic [`WORD_W-1:0] word_0;
        logic [`WORD_W-1:0] word_1;
        logic [`WORD_W-1:0] word_2;
        logic [`WORD_W-1:0] word_3;
    } fill_words_t;

    // Fetch data handed back to the core
    typedef struct packed {
        // Current word of the line being streamed
        logic [`WORD_W-1:0]   partial;
        // Line built up as the words go out
        logic [4*`WORD_W-1:0] line;
        // High with each valid partial word
        logic                 partial_done;
        // High together with the last word
        logic                 done;
    } core_fetch_t;

endpackage

// ==== hdl/ifill_req_issuer.sv ====
/*
 * Request side of the fetch bridge:
 * accepts core code-fetch strobes once the core is awake and
 * drives a held instruction-miss request until the header ack
 */

`include "ifill_defs.svh"

module ifill_req_issuer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    awake,
    input  logic                    readcode_do,
    input  logic [`CORE_ADDR_W-1:0] readcode_address,
    input  logic                    header_ack,
    input  logic                    fill_done,
    output ifill_pkg::l15_req_t     l15_req
);

    // Idle, request on the bus, waiting for the fill
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_PEND
    } state_t;

    state_t                  state;
    logic [`CORE_ADDR_W-1:0] addr_q;
    logic                    accept;

    // Strobes only count when awake and nothing is in flight
    assign accept = awake && readcode_do && (state == ST_IDLE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    // Val becomes visible the cycle after the strobe
                    if (accept) begin
                        state <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    // Hold until the cache takes the header
                    if (header_ack) begin
                        state <= fill_done ? ST_IDLE : ST_PEND;
                    end
                end
                ST_PEND: begin
                    if (fill_done) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Line-aligned fetch address, captured on an accepted strobe
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            addr_q <= '0;
        end else if (accept) begin
            addr_q <= {readcode_address[`CORE_ADDR_W-1:`LINE_OFFSET_W],
                       {`LINE_OFFSET_W{1'b0}}};
        end
    end

    // All request fields read zero while the core sleeps
    always_comb begin
        l15_req = '0;
        if (awake) begin
            l15_req.val     = (state == ST_REQ);
            l15_req.rqtype  = `IMISS_RQ;
            // Fetch width is fixed at one word
            l15_req.size    = `PCX_SZ_4B;
            // Sign-extend the core address onto the wider cache address
            l15_req.address = {{(`L15_ADDR_W - `CORE_ADDR_W){addr_q[`CORE_ADDR_W-1]}},
                               addr_q};
        end
    end

endmodule

// ==== hdl/l15_resp_decoder.sv ====
/*
 * Response side of the fetch bridge:
 * acks every cache response, latches the wake-up interrupt and
 * captures instruction fills with big to little endian swap
 */

`include "ifill_defs.svh"

module l15_resp_decoder (
    input  logic                   clk,
    input  logic                   rst_n,
    input  ifill_pkg::l15_resp_t   resp,
    output logic                   req_ack,
    output logic                   awake,
    output logic                   fill_done,
    output logic                   line_valid,
    output ifill_pkg::fill_words_t line_words
);

    import ifill_pkg::*;

    // Reverse byte order of one 32-bit word
    function automatic logic [`WORD_W-1:0] bswap(input logic [`WORD_W-1:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    logic        wake_hit;
    logic        fill_hit;
    logic        awake_q;
    logic        fill_q;
    fill_words_t swapped;

    // Every response is acked in the same cycle
    assign req_ack = resp.val;

    // Interrupt with wake field set to one releases the core
    assign wake_hit = resp.val && (resp.returntype == `INT_RET) &&
                      (resp.data_0[`WAKE_FIELD_LO +: 2] == 2'b01);

    assign fill_hit = resp.val && (resp.returntype == `IFILL_RET);

    // Upper half of each beat is the earlier word
    always_comb begin
        swapped.word_0 = bswap(resp.data_2[`L15_DATA_W-1:`WORD_W]);
        swapped.word_1 = bswap(resp.data_2[`WORD_W-1:0]);
        swapped.word_2 = bswap(resp.data_3[`L15_DATA_W-1:`WORD_W]);
        swapped.word_3 = bswap(resp.data_3[`WORD_W-1:0]);
    end

    // Wake flag is sticky until reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            awake_q <= 1'b0;
        end else if (wake_hit) begin
            awake_q <= 1'b1;
        end
    end

    // One-cycle pulse per fill
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fill_q <= 1'b0;
        end else begin
            fill_q <= fill_hit;
        end
    end

    // Fill line register, loaded only on a fill return
    always_ff @(posedge clk) begin
        if (fill_hit) begin
            line_words <= swapped;
        end
    end

    assign awake = awake_q;

    // Same pulse closes the request and starts the stream
    assign fill_done  = fill_q;
    assign line_valid = fill_q;

endmodule

// ==== hdl/fetch_line_streamer.sv ====
/*
 * Core side of the fetch bridge:
 * sends the four fill words one per cycle with a strobe each,
 * builds the 128-bit line and flags the last word
 */

`include "ifill_defs.svh"

module fetch_line_streamer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   awake,
    input  logic                   line_valid,
    input  ifill_pkg::fill_words_t line_words,
    output ifill_pkg::core_fetch_t fetch
);

    import ifill_pkg::*;

    fill_words_t          words_q;
    // Index of the next word to send while active
    logic [1:0]           word_cnt;
    logic                 active;
    logic [`WORD_W-1:0]   next_word;
    logic [`WORD_W-1:0]   partial_q;
    logic [4*`WORD_W-1:0] line_q;
    logic                 pdone_q;
    logic                 done_q;

    // Word 0 goes straight from line_words, the rest from words_q
    always_comb begin
        case (word_cnt)
            2'd1:    next_word = words_q.word_1;
            2'd2:    next_word = words_q.word_2;
            2'd3:    next_word = words_q.word_3;
            default: next_word = words_q.word_0;
        endcase
    end

    // Sequencer, a new line restarts from word 0
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active   <= 1'b0;
            word_cnt <= 2'd0;
            pdone_q  <= 1'b0;
            done_q   <= 1'b0;
        end else if (line_valid) begin
            active   <= 1'b1;
            word_cnt <= 2'd1;
            pdone_q  <= 1'b1;
            done_q   <= 1'b0;
        end else if (active) begin
            pdone_q  <= 1'b1;
            word_cnt <= word_cnt + 2'd1;
            // Last word ends the stream
            if (word_cnt == 2'd3) begin
                active <= 1'b0;
                done_q <= 1'b1;
            end else begin
                done_q <= 1'b0;
            end
        end else begin
            pdone_q <= 1'b0;
            done_q  <= 1'b0;
        end
    end

    // Word data and line build-up
    always_ff @(posedge clk) begin
        if (line_valid) begin
            words_q   <= line_words;
            partial_q <= line_words.word_0;
            // Line starts clean with word 0 at the bottom
            line_q    <= {{(3*`WORD_W){1'b0}}, line_words.word_0};
        end else if (active) begin
            partial_q <= next_word;
            // Older words move up, new word enters low
            line_q    <= {line_q[3*`WORD_W-1:0], next_word};
        end
    end

    // Core sees nothing until it is woken
    always_comb begin
        fetch = '0;
        if (awake) begin
            fetch.partial      = partial_q;
            fetch.line         = line_q;
            fetch.partial_done = pdone_q;
            fetch.done         = done_q;
        end
    end

endmodule

// ==== hdl/ao486_ifill_bridge.sv ====
/*
 * Instruction-fetch bridge between the x86 core and the L1.5:
 * request issuer, response decoder and line streamer
 */

`include "ifill_defs.svh"

module ao486_ifill_bridge (
    input  logic                    clk,
    input  logic                    rst_n,
    // Core fetch strobe and address
    input  logic                    readcode_do,
    input  logic [`CORE_ADDR_W-1:0] readcode_address,
    // Cache side inputs
    input  logic                    header_ack,
    input  ifill_pkg::l15_resp_t    resp,
    // Cache side outputs
    output ifill_pkg::l15_req_t     l15_req,
    output logic                    req_ack,
    // Core side outputs
    output ifill_pkg::core_fetch_t  fetch,
    output logic                    core_wake
);

    import ifill_pkg::*;

    logic        awake;
    logic        fill_done;
    logic        line_valid;
    fill_words_t line_words;

    // Miss request toward the cache
    ifill_req_issuer ifill_req_issuer_inst (
        .clk              (clk),
        .rst_n            (rst_n),
        .awake            (awake),
        .readcode_do      (readcode_do),
        .readcode_address (readcode_address),
        .header_ack       (header_ack),
        .fill_done        (fill_done),
        .l15_req          (l15_req)
    );

    // Ack, wake-up and fill capture
    l15_resp_decoder l15_resp_decoder_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .resp       (resp),
        .req_ack    (req_ack),
        .awake      (awake),
        .fill_done  (fill_done),
        .line_valid (line_valid),
        .line_words (line_words)
    );

    // Word stream back to the core
    fetch_line_streamer fetch_line_streamer_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .awake      (awake),
        .line_valid (line_valid),
        .line_words (line_words),
        .fetch      (fetch)
    );

    assign core_wake = awake;

endmodule

// ==== sim/ao486_ifill_bridge_asserts.sv ====
/*
 * Bound checks on the request handshake and the fetch stream
 */

`include "ifill_defs.svh"

module ao486_ifill_bridge_asserts (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   header_ack,
    input ifill_pkg::l15_req_t    l15_req,
    input ifill_pkg::core_fetch_t fetch,
    input logic                   line_valid
);

    // Request holds with a stable address until the header ack
    req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        l15_req.val && !header_ack |=> l15_req.val && $stable(l15_req.address))
        else $error("request dropped or address changed before header_ack");

    // Word strobes only within four cycles of a new line
    pdone_in_stream: assert property (@(posedge clk) disable iff (!rst_n)
        fetch.partial_done |-> $past(line_valid, 1) || $past(line_valid, 2) ||
                               $past(line_valid, 3) || $past(line_valid, 4))
        else $error("partial_done outside a line stream");

    // Stream is continuous up to the last word
    pdone_stream: assert property (@(posedge clk) disable iff (!rst_n)
        fetch.partial_done && !fetch.done && $past(fetch.done) == 1'b0 &&
        !($past(fetch.partial_done, 3) && $past(fetch.partial_done, 2) &&
          $past(fetch.partial_done, 1)) |=> fetch.partial_done)
        else $error("partial_done gap inside a stream");

    // Done comes with the fourth word
    done_fourth: assert property (@(posedge clk) disable iff (!rst_n)
        fetch.done |-> fetch.partial_done && $past(fetch.partial_done, 1) &&
                       $past(fetch.partial_done, 2) && $past(fetch.partial_done, 3))
        else $error("done without four partial words");

endmodule

bind ao486_ifill_bridge ao486_ifill_bridge_asserts ao486_ifill_bridge_asserts_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .header_ack (header_ack),
    .l15_req    (l15_req),
    .fetch      (fetch),
    .line_valid (line_valid)
);

// ==== sim/ao486_ifill_bridge_tb.sv ====
/*
 * Testbench for the instruction-fetch bridge:
 * clock, reset, seeded random stimulus, cache responder model,
 * fetch stream checker and final verdict
 */

`include "ifill_defs.svh"

module ao486_ifill_bridge_tb;

    import ifill_pkg::*;

    logic                    clk;
    logic                    rst_n;
    logic                    readcode_do;
    logic [`CORE_ADDR_W-1:0] readcode_address;
    logic                    header_ack;
    l15_resp_t               resp;
    l15_req_t                l15_req;
    logic                    req_ack;
    core_fetch_t             fetch;
    logic                    core_wake;

    integer                  seed;
    logic                    woken;
    logic [`CORE_ADDR_W-1:0] req_addr;
    logic [`L15_ADDR_W-1:0]  exp_addr;
    logic [`L15_DATA_W-1:0]  d2;
    logic [`L15_DATA_W-1:0]  d3;
    logic [`WORD_W-1:0]      exp_words [0:3];
    logic [4*`WORD_W-1:0]    exp_line;
    integer                  fill_idx;
    integer                  hdelay;
    integer                  fdelay;
    integer                  waited;
    integer                  k;

    ao486_ifill_bridge ao486_ifill_bridge_inst (
        .clk              (clk),
        .rst_n            (rst_n),
        .readcode_do      (readcode_do),
        .readcode_address (readcode_address),
        .header_ack       (header_ack),
        .resp             (resp),
        .l15_req          (l15_req),
        .req_ack          (req_ack),
        .fetch            (fetch),
        .core_wake        (core_wake)
    );

    // 10 time unit clock
    always #5 clk = ~clk;

    // Compare one value, stop on the first difference
    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
            $display("TEST FAIL");
            $fatal(1, "check failed");
        end
    endtask

    // Timeout on a wait loop
    task automatic report_timeout(input string what);
        $display("Timeout waiting for %s", what);
        $display("TEST FAIL");
        $fatal(1, "timeout");
    endtask

    // Advance to the next falling edge, req_ack checked there
    task automatic tick;
        @(negedge clk);
        check_value("req_ack", {127'b0, resp.val}, {127'b0, req_ack});
        if (woken) begin
            check_value("core_wake_sticky", 128'd1, {127'b0, core_wake});
        end
    endtask

    // Byte order reversal for the model, one byte at a time
    function automatic logic [`WORD_W-1:0] reverse_bytes(input logic [`WORD_W-1:0] w);
        logic [`WORD_W-1:0] r;
        integer b;
        r = '0;
        for (b = 0; b < 4; b = b + 1) begin
            r[8*(3-b) +: 8] = w[8*b +: 8];
        end
        return r;
    endfunction

    // Background response that is neither a fill nor an interrupt
    task automatic drive_idle_resp;
        logic [31:0] r;
        logic [3:0]  rt;
        r  = $random(seed);
        rt = r[3:0];
        if (rt == `IFILL_RET || rt == `INT_RET) begin
            rt = 4'b0000;
        end
        r               = $random(seed);
        resp.val        = r[0];
        resp.returntype = rt;
        resp.data_0     = {$random(seed), $random(seed)};
        resp.data_2     = {$random(seed), $random(seed)};
        resp.data_3     = {$random(seed), $random(seed)};
    endtask

    // Random strobe the DUT must ignore
    task automatic drive_noise_strobe;
        logic [31:0] r;
        r                = $random(seed);
        readcode_do      = r[0];
        readcode_address = $random(seed);
    endtask

    initial begin
        seed             = 18531;
        woken            = 1'b0;
        clk              = 1'b0;
        rst_n            = 1'b0;
        readcode_do      = 1'b0;
        readcode_address = '0;
        header_ack       = 1'b0;
        resp             = '0;

        // Reset for two cycles
        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        // Asleep, strobes and traffic must not reach the outputs
        // A fill now and then runs the stream behind the sleep gate
        for (k = 0; k < 40; k = k + 1) begin
            drive_noise_strobe();
            drive_idle_resp();
            if (k % 8 == 3) begin
                resp.val        = 1'b1;
                resp.returntype = `IFILL_RET;
            end
            tick();
            check_value("asleep_req", 128'd0, {79'b0, l15_req});
            check_value("asleep_wake", 128'd0, {127'b0, core_wake});
            check_value("asleep_pdone", 128'd0, {127'b0, fetch.partial_done});
            check_value("asleep_done", 128'd0, {127'b0, fetch.done});
        end
        readcode_do = 1'b0;

        // Interrupt with wake field two does not wake
        resp                              = '0;
        resp.val                          = 1'b1;
        resp.returntype                   = `INT_RET;
        resp.data_0[`WAKE_FIELD_LO +: 2] = 2'b10;
        tick();
        resp = '0;
        tick();
        check_value("wake_field_2", 128'd0, {127'b0, core_wake});

        // Wake field one sets it
        resp.val                          = 1'b1;
        resp.returntype                   = `INT_RET;
        resp.data_0[`WAKE_FIELD_LO +: 2] = 2'b01;
        tick();
        resp   = '0;
        waited = 0;
        while (!core_wake) begin
            if (waited > 4) begin
                report_timeout("core_wake after wake interrupt");
            end
            tick();
            waited = waited + 1;
        end
        woken = 1'b1;

        for (fill_idx = 0; fill_idx < 200; fill_idx = fill_idx + 1) begin
            // Nothing may be on the bus before the strobe
            check_value("val_before_strobe", 128'd0, {127'b0, l15_req.val});
            req_addr         = $random(seed);
            exp_addr         = {{(`L15_ADDR_W-`CORE_ADDR_W){req_addr[`CORE_ADDR_W-1]}},
                                req_addr[`CORE_ADDR_W-1:`LINE_OFFSET_W],
                                {`LINE_OFFSET_W{1'b0}}};
            readcode_do      = 1'b1;
            readcode_address = req_addr;
            drive_idle_resp();
            tick();
            readcode_do = 1'b0;
            check_value("req_val", 128'd1, {127'b0, l15_req.val});
            check_value("req_rqtype", {123'b0, `IMISS_RQ}, {123'b0, l15_req.rqtype});
            check_value("req_size", {125'b0, `PCX_SZ_4B}, {125'b0, l15_req.size});
            check_value("req_address", {88'b0, exp_addr}, {88'b0, l15_req.address});

            // Back-pressure, request holds and new strobes are ignored
            hdelay = $unsigned($random(seed)) % 6;
            repeat (hdelay) begin
                drive_noise_strobe();
                drive_idle_resp();
                tick();
                check_value("req_held_val", 128'd1, {127'b0, l15_req.val});
                check_value("req_held_addr", {88'b0, exp_addr}, {88'b0, l15_req.address});
            end
            readcode_do = 1'b0;
            header_ack  = 1'b1;
            drive_idle_resp();
            tick();
            header_ack = 1'b0;
            check_value("val_after_ack", 128'd0, {127'b0, l15_req.val});

            // Pending, strobes still ignored
            fdelay = 1 + ($unsigned($random(seed)) % 8);
            repeat (fdelay) begin
                drive_noise_strobe();
                drive_idle_resp();
                tick();
                check_value("val_pending", 128'd0, {127'b0, l15_req.val});
            end
            readcode_do = 1'b0;

            // Fill response, model swaps the bytes of each word
            d2              = {$random(seed), $random(seed)};
            d3              = {$random(seed), $random(seed)};
            exp_words[0]    = reverse_bytes(d2[63:32]);
            exp_words[1]    = reverse_bytes(d2[31:0]);
            exp_words[2]    = reverse_bytes(d3[63:32]);
            exp_words[3]    = reverse_bytes(d3[31:0]);
            resp            = '0;
            resp.val        = 1'b1;
            resp.returntype = `IFILL_RET;
            resp.data_2     = d2;
            resp.data_3     = d3;
            tick();
            resp.val = 1'b0;

            waited = 0;
            while (!fetch.partial_done) begin
                check_value("done_early", 128'd0, {127'b0, fetch.done});
                if (waited > 8) begin
                    report_timeout("first partial_done of fill");
                end
                drive_idle_resp();
                tick();
                waited = waited + 1;
            end
            // Word 0 lands one cycle after the fill pulse
            check_value("fill_latency", 128'd1, {96'b0, waited});

            // Four words on consecutive cycles
            exp_line = '0;
            for (k = 0; k < 4; k = k + 1) begin
                exp_line = {exp_line[3*`WORD_W-1:0], exp_words[k]};
                check_value("partial_word", {96'b0, exp_words[k]}, {96'b0, fetch.partial});
                check_value("partial_done", 128'd1, {127'b0, fetch.partial_done});
                check_value("done_pulse", {127'b0, k == 3}, {127'b0, fetch.done});
                check_value("line_build", exp_line, fetch.line);
                check_value("val_streaming", 128'd0, {127'b0, l15_req.val});
                if (k < 3) begin
                    drive_idle_resp();
                    tick();
                end
            end
            check_value("line_final", {exp_words[0], exp_words[1], exp_words[2],
                                       exp_words[3]}, fetch.line);
            drive_idle_resp();
            tick();
            check_value("pdone_after", 128'd0, {127'b0, fetch.partial_done});
            check_value("done_after", 128'd0, {127'b0, fetch.done});
        end

        $display("TEST PASS");
        $finish;
    end

    // Global limit in case a loop misbehaves
    initial begin
        repeat (20000) @(posedge clk);
        $display("Simulation limit reached before the test finished");
        $display("TEST FAIL");
        $fatal(1, "global timeout");
    end

endmodule

// ==== flist.f ====
+incdir+hdl
hdl/ifill_pkg.sv
hdl/ifill_req_issuer.sv
hdl/l15_resp_decoder.sv
hdl/fetch_line_streamer.sv
hdl/ao486_ifill_bridge.sv
sim/ao486_ifill_bridge_asserts.sv
sim/ao486_ifill_bridge_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
FLIST      := flist.f
TOP        := ao486_ifill_bridge_tb
RTL_TOP    := ao486_ifill_bridge
OBJ_DIR    := obj_dir
LOG        := sim.log
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(shell grep -v '^+' $(FLIST)) hdl/ifill_defs.svh
	$(VERILATOR) $(SIM_FLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then echo "No verdict in log"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
